/* source/cache_geometry_pkg.sv */
package cache_geometry_pkg;

    // 256 bytes as 8 sets of 4 ways with 8-byte blocks
    localparam int num_sets = 8;
    localparam int num_ways = 4;
    localparam int block_bytes = 8;

    // outstanding misses
    localparam int buffer_depth = 4;

    // address is {tag[15:6], set[5:3], offset[2:0]}
    typedef logic [15:0] addr_t;
    typedef logic [9:0] tag_t;
    typedef logic [2:0] set_t;
    typedef logic [1:0] way_t;

    typedef logic [63:0] block_t;
    typedef logic [31:0] word_t;

    // {b2, b1, b0} tree bits of one set
    typedef logic [2:0] plru_t;

    typedef enum logic [1:0] {
        size_byte = 2'h0,
        size_half = 2'h1,
        size_word = 2'h2
    } load_size_t;

endpackage

/* source/mem_bus_pkg.sv */
package mem_bus_pkg;

    // zero is never a valid tag
    typedef logic [3:0] mem_tag_t;

    typedef enum logic [1:0] {
        bus_none = 2'h0,
        bus_load = 2'h1
    } bus_command_t;

    // comes back with the result
    typedef logic [5:0] req_id_t;

endpackage

/* source/cache_way_if.sv */
`timescale 1ns/1ps

interface cache_way_if;

    // lookup result of the way
    logic hit;
    cache_geometry_pkg::block_t data;

    // block write from the miss buffer
    logic fill_enable;
    cache_geometry_pkg::set_t fill_set;
    cache_geometry_pkg::tag_t fill_tag;
    cache_geometry_pkg::block_t fill_data;

    modport way (
        output hit, data,
        input fill_enable, fill_set, fill_tag, fill_data
    );

    modport filler (output fill_enable, fill_set, fill_tag, fill_data);

    modport reader (input hit, data);

endinterface

/* source/cache_way.sv */
`timescale 1ns/1ps

module cache_way (
    input  logic                     clock,
    input  logic                     reset,
    input  cache_geometry_pkg::set_t lookup_set,
    input  cache_geometry_pkg::tag_t lookup_tag,
    cache_way_if.way                 port
);

    logic [cache_geometry_pkg::num_sets-1:0] valid_bits;
    cache_geometry_pkg::tag_t tag_mem [cache_geometry_pkg::num_sets];
    cache_geometry_pkg::block_t data_mem [cache_geometry_pkg::num_sets];

    // combinational read of the addressed block
    assign port.hit = valid_bits[lookup_set] && (tag_mem[lookup_set] == lookup_tag);
    assign port.data = data_mem[lookup_set];

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (port.fill_enable) begin
            valid_bits[port.fill_set] <= 1'b1;
        end
    end

    // tag and data arrays
    always_ff @(posedge clock) begin
        if (port.fill_enable) begin
            tag_mem[port.fill_set] <= port.fill_tag;
            data_mem[port.fill_set] <= port.fill_data;
        end
    end

endmodule

/* source/tree_plru.sv */
`timescale 1ns/1ps

module tree_plru (
    input  logic                     clock,
    input  logic                     reset,
    input  cache_geometry_pkg::set_t lookup_set,
    input  logic                     update_enable,
    input  cache_geometry_pkg::set_t update_set,
    input  cache_geometry_pkg::way_t update_way,
    output cache_geometry_pkg::way_t victim_way
);

    cache_geometry_pkg::plru_t tree_state [cache_geometry_pkg::num_sets];
    cache_geometry_pkg::plru_t lookup_state;
    cache_geometry_pkg::plru_t update_state;

    assign lookup_state = tree_state[lookup_set];
    assign update_state = tree_state[update_set];

    // b0 picks the pair, b1 or b2 the way inside it
    always_comb begin
        if (lookup_state[0]) begin
            victim_way = lookup_state[2] ? 2'd3 : 2'd2;
        end else begin
            victim_way = lookup_state[1] ? 2'd1 : 2'd0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < cache_geometry_pkg::num_sets; s++) begin
                tree_state[s] <= '0;
            end
        end else if (update_enable) begin
            // point the tree away from the way just used
            case (update_way)
                2'd0: tree_state[update_set] <= {update_state[2], 2'b11};
                2'd1: tree_state[update_set] <= {update_state[2], 2'b01};
                2'd2: tree_state[update_set] <= {1'b1, update_state[1], 1'b0};
                default: tree_state[update_set] <= {1'b0, update_state[1], 1'b0};
            endcase
        end
    end

    update_way_known: assert property (
        @(posedge clock) disable iff (reset) update_enable |-> !$isunknown(update_way)
    );

endmodule

/* source/miss_buffer.sv */
`timescale 1ns/1ps

module miss_buffer (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             load_valid,
    input  cache_geometry_pkg::addr_t        load_addr,
    input  cache_geometry_pkg::load_size_t   load_size,
    input  logic                             load_signed,
    input  mem_bus_pkg::req_id_t             load_id,
    input  logic                             lookup_hit,
    input  cache_geometry_pkg::way_t         victim_way,
    input  logic                             mem_response_valid,
    input  mem_bus_pkg::mem_tag_t            mem_response,
    input  cache_geometry_pkg::block_t       mem_data,
    input  mem_bus_pkg::mem_tag_t            mem_data_tag,
    cache_way_if.filler                      fill_ports [cache_geometry_pkg::num_ways],
    output mem_bus_pkg::bus_command_t        mem_command,
    output cache_geometry_pkg::addr_t        mem_addr,
    output logic                             buffer_full,
    output logic                             head_done,
    output cache_geometry_pkg::block_t       head_data,
    output logic [2:0]                       head_offset_word,
    output cache_geometry_pkg::load_size_t   head_size,
    output logic                             head_signed,
    output mem_bus_pkg::req_id_t             head_id,
    output logic                             plru_fill_enable,
    output cache_geometry_pkg::set_t         plru_fill_set,
    output cache_geometry_pkg::way_t         plru_fill_way
);

    localparam int depth = cache_geometry_pkg::buffer_depth;

    typedef logic [$clog2(depth)-1:0] ptr_t;

    ptr_t head_ptr;
    ptr_t send_ptr;
    ptr_t tail_ptr;

    // control state per entry
    logic [depth-1:0] entry_valid;
    logic [depth-1:0] entry_done;
    mem_bus_pkg::mem_tag_t entry_tag [depth];

    // payload per entry
    cache_geometry_pkg::addr_t entry_addr [depth];
    cache_geometry_pkg::load_size_t entry_size [depth];
    logic [depth-1:0] entry_signed;
    mem_bus_pkg::req_id_t entry_id [depth];
    cache_geometry_pkg::set_t entry_set [depth];
    cache_geometry_pkg::way_t entry_way [depth];
    cache_geometry_pkg::block_t entry_data [depth];

    logic enqueue;
    logic retire;
    logic send_pending;
    logic tag_accept;
    logic [depth-1:0] capture;

    function automatic ptr_t next_ptr(input ptr_t ptr);
        return (ptr == ptr_t'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // full when the tail has caught up with a live head
    assign buffer_full = entry_valid[tail_ptr];
    assign enqueue = load_valid && !lookup_hit;

    assign head_done = entry_valid[head_ptr] && entry_done[head_ptr];
    assign retire = head_done && !lookup_hit;

    // oldest entry still waiting for a memory tag
    assign send_pending = entry_valid[send_ptr] && (entry_tag[send_ptr] == '0);
    assign mem_command = send_pending ? mem_bus_pkg::bus_load : mem_bus_pkg::bus_none;
    assign mem_addr = entry_addr[send_ptr] & ~cache_geometry_pkg::addr_t'(
        cache_geometry_pkg::block_bytes - 1);
    assign tag_accept = mem_response_valid && (mem_response != '0);

    always_comb begin
        for (int i = 0; i < depth; i++) begin
            capture[i] = entry_valid[i] && !entry_done[i] && (mem_data_tag != '0)
                && (entry_tag[i] == mem_data_tag);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr <= '0;
            send_ptr <= '0;
            tail_ptr <= '0;
            entry_valid <= '0;
            entry_done <= '0;
            for (int i = 0; i < depth; i++) begin
                entry_tag[i] <= '0;
            end
        end else begin
            entry_done <= entry_done | capture;
            if (tag_accept) begin
                entry_tag[send_ptr] <= mem_response;
                send_ptr <= next_ptr(send_ptr);
            end
            if (retire) begin
                entry_valid[head_ptr] <= 1'b0;
                head_ptr <= next_ptr(head_ptr);
            end
            if (enqueue) begin
                entry_valid[tail_ptr] <= 1'b1;
                entry_done[tail_ptr] <= 1'b0;
                entry_tag[tail_ptr] <= '0;
                tail_ptr <= next_ptr(tail_ptr);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enqueue) begin
            entry_addr[tail_ptr] <= load_addr;
            entry_size[tail_ptr] <= load_size;
            entry_signed[tail_ptr] <= load_signed;
            entry_id[tail_ptr] <= load_id;
            entry_set[tail_ptr] <= cache_geometry_pkg::set_t'(load_addr >> 3);
            entry_way[tail_ptr] <= victim_way;
        end
        for (int i = 0; i < depth; i++) begin
            if (capture[i]) begin
                entry_data[i] <= mem_data;
            end
        end
    end

    assign head_data = entry_data[head_ptr];
    assign head_offset_word = entry_addr[head_ptr][2:0];
    assign head_size = entry_size[head_ptr];
    assign head_signed = entry_signed[head_ptr];
    assign head_id = entry_id[head_ptr];

    // retirement writes the way chosen at enqueue time
    for (genvar w = 0; w < cache_geometry_pkg::num_ways; w++) begin : g_fill
        assign fill_ports[w].fill_enable = retire
            && (entry_way[head_ptr] == cache_geometry_pkg::way_t'(w));
        assign fill_ports[w].fill_set = entry_set[head_ptr];
        assign fill_ports[w].fill_tag = cache_geometry_pkg::tag_t'(entry_addr[head_ptr] >> 6);
        assign fill_ports[w].fill_data = entry_data[head_ptr];
    end

    assign plru_fill_enable = retire;
    assign plru_fill_set = entry_set[head_ptr];
    assign plru_fill_way = entry_way[head_ptr];

    no_enqueue_when_full: assert property (
        @(posedge clock) disable iff (reset) enqueue |-> !buffer_full
    );

endmodule

/* source/load_return.sv */
`timescale 1ns/1ps

module load_return (
    cache_way_if.reader                      readers [cache_geometry_pkg::num_ways],
    input  logic                             load_valid,
    input  cache_geometry_pkg::addr_t        load_addr,
    input  cache_geometry_pkg::load_size_t   load_size,
    input  logic                             load_signed,
    input  mem_bus_pkg::req_id_t             load_id,
    input  logic                             head_done,
    input  cache_geometry_pkg::block_t       head_data,
    input  logic [2:0]                       head_offset_word,
    input  cache_geometry_pkg::load_size_t   head_size,
    input  logic                             head_signed,
    input  mem_bus_pkg::req_id_t             head_id,
    output logic                             lookup_hit,
    output cache_geometry_pkg::way_t         hit_way,
    output logic                             result_valid,
    output cache_geometry_pkg::word_t        result_value,
    output mem_bus_pkg::req_id_t             result_id
);

    logic [cache_geometry_pkg::num_ways-1:0] way_hit;
    cache_geometry_pkg::block_t way_data [cache_geometry_pkg::num_ways];
    cache_geometry_pkg::block_t hit_data;

    // word by bit 2, then byte or half by bits 1 to 0
    function automatic cache_geometry_pkg::word_t extract(
        input cache_geometry_pkg::block_t data,
        input logic [2:0] offset,
        input cache_geometry_pkg::load_size_t size,
        input logic sign
    );
        cache_geometry_pkg::word_t word;
        logic [7:0] byte_val;
        logic [15:0] half_val;
        word = offset[2] ? data[63:32] : data[31:0];
        byte_val = word[8*offset[1:0] +: 8];
        half_val = word[16*offset[1] +: 16];
        case (size)
            cache_geometry_pkg::size_byte: return {{24{sign && byte_val[7]}}, byte_val};
            cache_geometry_pkg::size_half: return {{16{sign && half_val[15]}}, half_val};
            default: return word;
        endcase
    endfunction

    for (genvar w = 0; w < cache_geometry_pkg::num_ways; w++) begin : g_read
        assign way_hit[w] = readers[w].hit;
        assign way_data[w] = readers[w].data;
    end

    assign lookup_hit = load_valid && (|way_hit);

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < cache_geometry_pkg::num_ways; w++) begin
            if (way_hit[w]) begin
                hit_way = cache_geometry_pkg::way_t'(w);
            end
        end
    end

    assign hit_data = way_data[hit_way];

    // a hit wins the port, a done head waits
    assign result_valid = lookup_hit || head_done;
    assign result_value = lookup_hit ? extract(hit_data, load_addr[2:0], load_size, load_signed)
        : extract(head_data, head_offset_word, head_size, head_signed);
    assign result_id = lookup_hit ? load_id : head_id;

endmodule

/* source/dcache.sv */
`timescale 1ns/1ps

module dcache (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             load_valid,
    input  cache_geometry_pkg::addr_t        load_addr,
    input  cache_geometry_pkg::load_size_t   load_size,
    input  logic                             load_signed,
    input  mem_bus_pkg::req_id_t             load_id,
    input  logic                             mem_response_valid,
    input  mem_bus_pkg::mem_tag_t            mem_response,
    input  cache_geometry_pkg::block_t       mem_data,
    input  mem_bus_pkg::mem_tag_t            mem_data_tag,
    output logic                             result_valid,
    output cache_geometry_pkg::word_t        result_value,
    output mem_bus_pkg::req_id_t             result_id,
    output mem_bus_pkg::bus_command_t        mem_command,
    output cache_geometry_pkg::addr_t        mem_addr,
    output logic                             buffer_full
);

    cache_geometry_pkg::tag_t load_tag;
    cache_geometry_pkg::set_t load_set;

    logic lookup_hit;
    cache_geometry_pkg::way_t hit_way;
    cache_geometry_pkg::way_t victim_way;

    logic head_done;
    cache_geometry_pkg::block_t head_data;
    logic [2:0] head_offset_word;
    cache_geometry_pkg::load_size_t head_size;
    logic head_signed;
    mem_bus_pkg::req_id_t head_id;

    logic plru_fill_enable;
    cache_geometry_pkg::set_t plru_fill_set;
    cache_geometry_pkg::way_t plru_fill_way;

    logic plru_update_enable;
    cache_geometry_pkg::set_t plru_update_set;
    cache_geometry_pkg::way_t plru_update_way;

    assign load_tag = cache_geometry_pkg::tag_t'(load_addr >> 6);
    assign load_set = cache_geometry_pkg::set_t'(load_addr >> 3);

    cache_way_if way_bus [cache_geometry_pkg::num_ways] ();

    for (genvar w = 0; w < cache_geometry_pkg::num_ways; w++) begin : g_way
        cache_way way_i (
            .clock(clock),
            .reset(reset),
            .lookup_set(load_set),
            .lookup_tag(load_tag),
            .port(way_bus[w])
        );
    end

    // a fill only retires without a hit, so the two never collide
    assign plru_update_enable = lookup_hit || plru_fill_enable;
    assign plru_update_set = lookup_hit ? load_set : plru_fill_set;
    assign plru_update_way = lookup_hit ? hit_way : plru_fill_way;

    tree_plru plru_i (
        .clock(clock),
        .reset(reset),
        .lookup_set(load_set),
        .update_enable(plru_update_enable),
        .update_set(plru_update_set),
        .update_way(plru_update_way),
        .victim_way(victim_way)
    );

    miss_buffer miss_i (
        .clock(clock),
        .reset(reset),
        .load_valid(load_valid),
        .load_addr(load_addr),
        .load_size(load_size),
        .load_signed(load_signed),
        .load_id(load_id),
        .lookup_hit(lookup_hit),
        .victim_way(victim_way),
        .mem_response_valid(mem_response_valid),
        .mem_response(mem_response),
        .mem_data(mem_data),
        .mem_data_tag(mem_data_tag),
        .fill_ports(way_bus),
        .mem_command(mem_command),
        .mem_addr(mem_addr),
        .buffer_full(buffer_full),
        .head_done(head_done),
        .head_data(head_data),
        .head_offset_word(head_offset_word),
        .head_size(head_size),
        .head_signed(head_signed),
        .head_id(head_id),
        .plru_fill_enable(plru_fill_enable),
        .plru_fill_set(plru_fill_set),
        .plru_fill_way(plru_fill_way)
    );

    load_return return_i (
        .readers(way_bus),
        .load_valid(load_valid),
        .load_addr(load_addr),
        .load_size(load_size),
        .load_signed(load_signed),
        .load_id(load_id),
        .head_done(head_done),
        .head_data(head_data),
        .head_offset_word(head_offset_word),
        .head_size(head_size),
        .head_signed(head_signed),
        .head_id(head_id),
        .lookup_hit(lookup_hit),
        .hit_way(hit_way),
        .result_valid(result_valid),
        .result_value(result_value),
        .result_id(result_id)
    );

endmodule

/* verif/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;

    logic clock;
    logic reset;
    logic load_valid;
    cache_geometry_pkg::addr_t load_addr;
    cache_geometry_pkg::load_size_t load_size;
    logic load_signed;
    mem_bus_pkg::req_id_t load_id;
    logic mem_response_valid;
    mem_bus_pkg::mem_tag_t mem_response;
    cache_geometry_pkg::block_t mem_data;
    mem_bus_pkg::mem_tag_t mem_data_tag;
    logic result_valid;
    cache_geometry_pkg::word_t result_value;
    mem_bus_pkg::req_id_t result_id;
    mem_bus_pkg::bus_command_t mem_command;
    cache_geometry_pkg::addr_t mem_addr;
    logic buffer_full;

    // pattern table indexed by line
    int num_lines;
    logic [5:0] pat_id [64];
    logic [15:0] pat_addr [64];
    logic [1:0] pat_size [64];
    logic pat_signed [64];

    // per id bookkeeping
    logic [31:0] expect_by_id [64];
    logic known [64];
    logic seen [64];
    logic [1:0] miss_way [64];
    logic [9:0] miss_tag [64];
    int returned;

    // reference cache state
    logic model_valid [8][4];
    logic [9:0] model_tag [8][4];
    logic [2:0] model_plru [8];
    logic set_busy [8];
    int order_q [$];
    logic [15:0] issue_q [$];

    // memory model
    logic [3:0] pend_tag [$];
    logic [15:0] pend_addr [$];
    int pend_due [$];
    logic [3:0] next_tag;

    logic cur_valid;
    logic cur_hit;
    logic [5:0] cur_id;
    int cycles;
    int limit;

    dcache dcache_i (.*);

    task automatic stop_on_failure(input string msg);
        $display("%0t: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: got %h expected %h", $time, name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    // b0 picks the pair, b1 and b2 the way inside it
    function automatic logic [1:0] plru_victim(input logic [2:0] bits);
        if (bits[0]) begin
            return bits[2] ? 2'd3 : 2'd2;
        end
        return bits[1] ? 2'd1 : 2'd0;
    endfunction

    function automatic logic [2:0] plru_touch(input logic [2:0] bits, input logic [1:0] way);
        logic [2:0] next;
        next = bits;
        case (way)
            2'd0: next = {bits[2], 1'b1, 1'b1};
            2'd1: next = {bits[2], 1'b0, 1'b1};
            2'd2: next = {1'b1, bits[1], 1'b0};
            default: next = {1'b0, bits[1], 1'b0};
        endcase
        return next;
    endfunction

    // every byte is its low address byte xor a5
    function automatic logic [63:0] block_for(input logic [15:0] base);
        logic [63:0] data;
        logic [15:0] a;
        for (int i = 0; i < 8; i++) begin
            a = base + 16'(i);
            data[8*i +: 8] = a[7:0] ^ 8'hA5;
        end
        return data;
    endfunction

    task automatic read_patterns();
        int fd;
        int count;
        string line;
        logic [31:0] f_id, f_addr, f_size, f_sign, f_exp;
        fd = $fopen("verif/dcache_patterns.txt", "r");
        if (fd == 0) begin
            stop_on_failure("cannot open the pattern file");
        end
        num_lines = 0;
        while ($fgets(line, fd) != 0) begin
            count = $sscanf(line, "%h %h %h %h %h", f_id, f_addr, f_size, f_sign, f_exp);
            if (line.len() > 0 && line[0] != "#" && count == 5) begin
                pat_id[num_lines] = f_id[5:0];
                pat_addr[num_lines] = f_addr[15:0];
                pat_size[num_lines] = f_size[1:0];
                pat_signed[num_lines] = f_sign[0];
                expect_by_id[f_id[5:0]] = f_exp;
                known[f_id[5:0]] = 1'b1;
                num_lines++;
            end
        end
        $fclose(fd);
    endtask

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            stop_on_failure("timeout, results still outstanding");
        end
    end

    // tag answer in the same cycle, data 2 to 6 cycles later
    always @(posedge clock) begin
        #1;
        mem_data_tag = '0;
        for (int i = 0; i < pend_tag.size(); i++) begin
            if (pend_due[i] <= cycles) begin
                mem_data_tag = pend_tag[i];
                mem_data = block_for(pend_addr[i]);
                pend_tag.delete(i);
                pend_addr.delete(i);
                pend_due.delete(i);
                break;
            end
        end
        mem_response_valid = 1'b0;
        mem_response = '0;
        if (!reset && mem_command == mem_bus_pkg::bus_load) begin
            if (issue_q.size() == 0) begin
                stop_on_failure("bus_load issued with no miss pending");
            end
            check_value("mem_addr", mem_addr, issue_q.pop_front());
            mem_response_valid = 1'b1;
            mem_response = next_tag;
            pend_tag.push_back(next_tag);
            pend_addr.push_back(mem_addr);
            pend_due.push_back(cycles + 2 + int'($urandom % 5));
            next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        end
    end

    // result port sampled mid cycle
    always @(negedge clock) begin
        logic [5:0] id;
        logic [2:0] set;
        if (!reset && cur_valid) begin
            check_value("load_hit", result_valid && result_id == cur_id, cur_hit);
        end
        if (!reset && result_valid) begin
            id = result_id;
            if (!known[id] || seen[id]) begin
                stop_on_failure("result id unknown or returned twice");
            end
            check_value("result_value", result_value, expect_by_id[id]);
            seen[id] = 1'b1;
            returned++;
            if (!(cur_valid && id == cur_id)) begin
                check_value("result_id", id, order_q.pop_front());
                set = set_of_id(id);
                model_valid[set][miss_way[id]] = 1'b1;
                model_tag[set][miss_way[id]] = miss_tag[id];
                model_plru[set] = plru_touch(model_plru[set], miss_way[id]);
                set_busy[set] = 1'b0;
            end
        end
    end

    function automatic logic [2:0] set_of_id(input logic [5:0] id);
        for (int i = 0; i < num_lines; i++) begin
            if (pat_id[i] == id) begin
                return pat_addr[i][5:3];
            end
        end
        return 3'd0;
    endfunction

    initial begin
        logic [2:0] set;
        logic [9:0] tag;
        logic hit;
        logic [1:0] way;
        void'($urandom(46631));
        reset = 1'b1;
        load_valid = 1'b0;
        load_addr = '0;
        load_size = cache_geometry_pkg::size_word;
        load_signed = 1'b0;
        load_id = '0;
        mem_response_valid = 1'b0;
        mem_response = '0;
        mem_data = '0;
        mem_data_tag = '0;
        next_tag = 4'd1;
        cur_valid = 1'b0;
        cur_hit = 1'b0;
        cur_id = '0;
        cycles = 0;
        limit = 0;
        returned = 0;
        for (int i = 0; i < 64; i++) begin
            known[i] = 1'b0;
            seen[i] = 1'b0;
        end
        for (int s = 0; s < 8; s++) begin
            model_plru[s] = '0;
            set_busy[s] = 1'b0;
            for (int w = 0; w < 4; w++) begin
                model_valid[s][w] = 1'b0;
            end
        end
        read_patterns();
        limit = 40 * num_lines + 100;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        check_value("result_valid", result_valid, 1'b0);
        check_value("mem_command", mem_command, mem_bus_pkg::bus_none);
        check_value("buffer_full", buffer_full, 1'b0);
        @(posedge clock);
        #1;
        for (int i = 0; i < num_lines; i++) begin
            set = pat_addr[i][5:3];
            tag = pat_addr[i][15:6];
            // full exactly when four misses are still unreturned
            check_value("buffer_full", buffer_full,
                        order_q.size() == cache_geometry_pkg::buffer_depth);
            // one miss per set at a time keeps the reference tree exact
            while (buffer_full || set_busy[set]) begin
                @(posedge clock);
                #1;
                load_valid = 1'b0;
                cur_valid = 1'b0;
                check_value("buffer_full", buffer_full,
                            order_q.size() == cache_geometry_pkg::buffer_depth);
            end
            hit = 1'b0;
            way = '0;
            for (int w = 0; w < 4; w++) begin
                if (model_valid[set][w] && model_tag[set][w] == tag) begin
                    hit = 1'b1;
                    way = 2'(w);
                end
            end
            if (hit) begin
                model_plru[set] = plru_touch(model_plru[set], way);
            end else begin
                miss_way[pat_id[i]] = plru_victim(model_plru[set]);
                miss_tag[pat_id[i]] = tag;
                set_busy[set] = 1'b1;
                order_q.push_back(int'(pat_id[i]));
                issue_q.push_back(pat_addr[i] & ~16'h0007);
            end
            load_valid = 1'b1;
            load_addr = pat_addr[i];
            load_size = cache_geometry_pkg::load_size_t'(pat_size[i]);
            load_signed = pat_signed[i];
            load_id = pat_id[i];
            cur_valid = 1'b1;
            cur_hit = hit;
            cur_id = pat_id[i];
            @(posedge clock);
            #1;
            load_valid = 1'b0;
            cur_valid = 1'b0;
        end
        while (order_q.size() != 0) begin
            @(posedge clock);
        end
        check_value("returned_count", returned, num_lines);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* verif/dcache_patterns.txt */
# columns: id address size(0 byte, 1 half, 2 word) signed expected, all hex
# memory byte at an address is its low address byte xor a5
01 0000 2 0 a6a7a4a5
02 0004 2 0 a2a3a0a1
03 0001 0 1 ffffffa4
04 0002 0 0 000000a7
05 0003 0 1 ffffffa6
06 0005 0 0 000000a0
07 0006 0 1 ffffffa3
08 0007 0 0 000000a2
09 0002 1 1 ffffa6a7
0a 0006 1 0 0000a2a3
0b 0089 0 1 0000002c
0c 008e 1 1 00002a2b
0d 008c 2 1 2a2b2829
0e 0004 1 0 0000a0a1
0f 0010 2 0 b6b7b4b5
10 001c 2 0 babbb8b9
11 0020 0 1 ffffff85
12 002a 1 0 00008e8f
13 0030 2 0 96979495
14 0078 2 0 dedfdcdd
15 00b8 2 0 1e1f1c1d
16 00f8 2 0 5e5f5c5d
17 0138 2 0 9e9f9c9d
18 0178 2 0 dedfdcdd
19 007c 2 0 dadbd8d9
1a 013a 1 1 ffff9e9f

/* dcache.f */
source/cache_geometry_pkg.sv
source/mem_bus_pkg.sv
source/cache_way_if.sv
source/cache_way.sv
source/tree_plru.sv
source/miss_buffer.sv
source/load_return.sv
source/dcache.sv
verif/dcache_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST ?= dcache.f
TB_TOP ?= dcache_tb
RTL_TOP ?= dcache
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
